/* memsys.f */
+incdir+src
+incdir+bench
src/memsys_pkg.sv
src/port_router.sv
src/block_cache.sv
src/ram_arbiter.sv
src/block_ram.sv
src/memsys_top.sv
bench/tb_memsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory system testbench with Verilator
# Pass only when the testbench prints its pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_memsys -f memsys.f -o sim_memsys \
    || { echo "Verilator build failed"; exit 1; }

sim_output="$(./obj_dir/sim_memsys 2>&1)"
echo "$sim_output"

echo "$sim_output" | grep -qx "all tests passed" \
    && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }

/* bench/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

////////////////////////////////////////
// Checking and helpers
////////////////////////////////////////

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
        $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("tests failed");
        $fatal(1);
    end
endtask

// Only enabled bytes replace the old word
function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                            input logic [31:0] new_word,
                                            input logic [3:0]  be);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
            result[8*b +: 8] = new_word[8*b +: 8];
        end
    end
    return result;
endfunction

task automatic apply_reset();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
endtask

// Falling edge sample once the stall is gone
task automatic wait_no_stall();
    @(negedge clk);
    while (mem_stall) begin
        @(negedge clk);
    end
endtask

// One fetch plus one data access, checked against the shadow
task automatic mem_access(input logic [29:0] fetch_addr, input logic rd, input logic wr,
                          input logic [3:0] be, input logic [29:0] addr,
                          input logic [31:0] wdata);
    logic [31:0] fetch_exp;
    logic [31:0] load_exp;
    @(posedge clk);
    ic_addr       <= fetch_addr;
    dmem_read     <= rd;
    dmem_write    <= wr;
    dc_byte_w_en  <= be;
    dmem_addr     <= addr;
    data_from_reg <= wdata;
    wait_no_stall();
    fetch_exp = shadow[fetch_addr[13:0]];
    load_exp  = shadow[addr[13:0]];
    check_value("ic_data_out", ic_data_out, fetch_exp);
    if (rd) begin
        check_value("dmem_data_out", dmem_data_out, load_exp);
    end
    // Store lands on the coming rising edge
    if (wr) begin
        shadow[addr[13:0]] = merge_bytes(load_exp, wdata, be);
    end
    @(posedge clk);
    dmem_read  <= 1'b0;
    dmem_write <= 1'b0;
endtask

////////////////////////////////////////
// Tests
////////////////////////////////////////

task automatic test_reset_state();
    // Empty cache, so the first fetch of word 0 misses
    wait_no_stall();
    check_value("ic_data_out", ic_data_out, 32'h0);
    // Line present now, quiet cycle
    @(negedge clk);
    check_value("mem_stall", {31'd0, mem_stall}, 32'h0);
    mem_access(30'd0, 1'b1, 1'b0, 4'h0, 30'h020, 32'h0);
endtask

task automatic test_store_load();
    logic [29:0] addrs [4];
    addrs = '{30'h010, 30'h011, 30'h05C, 30'h2A3};
    foreach (addrs[i]) begin
        mem_access(30'd0, 1'b0, 1'b1, 4'hF, addrs[i], 32'hA500_0000 ^ {addrs[i], 2'b00});
    end
    // Second pass over each address hits
    for (int pass = 0; pass < 2; pass++) begin
        foreach (addrs[i]) begin
            mem_access(30'd0, 1'b1, 1'b0, 4'h0, addrs[i], 32'h0);
        end
    end
endtask

task automatic test_byte_enables();
    logic [29:0] addrs [4];
    logic [3:0]  bes   [4];
    logic [31:0] words [4];
    addrs = '{30'h010, 30'h011, 30'h05C, 30'h0F0};
    bes   = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
    words = '{32'h1122_3344, 32'h5566_7788, 32'h99AA_BBCC, 32'hDDEE_FF00};
    foreach (addrs[i]) begin
        mem_access(30'd0, 1'b0, 1'b1, bes[i], addrs[i], words[i]);
    end
    foreach (addrs[i]) begin
        mem_access(30'd0, 1'b1, 1'b0, 4'h0, addrs[i], 32'h0);
    end
endtask

task automatic test_dirty_eviction();
    logic [29:0] a_addr;
    logic [29:0] b_addr;
    // Same index and word, tag differs
    a_addr = 30'h0150;
    b_addr = 30'h1150;
    mem_access(30'd0, 1'b0, 1'b1, 4'hF, a_addr, 32'hCAFE_0150);
    mem_access(30'd0, 1'b0, 1'b1, 4'hF, b_addr, 32'hBEEF_1150);
    // Fetch reads RAM while the load evicts dirty B
    mem_access(a_addr, 1'b1, 1'b0, 4'h0, a_addr, 32'h0);
    mem_access(a_addr, 1'b1, 1'b0, 4'h0, b_addr, 32'h0);
endtask

task automatic test_random_stress();
    logic [31:0] r_addr;
    logic [31:0] r_fetch;
    logic [31:0] r_op;
    logic [31:0] r_data;
    for (int n = 0; n < MAX_ACCESSES; n++) begin
        r_addr  = $urandom();
        r_fetch = $urandom();
        r_op    = $urandom();
        r_data  = $urandom();
        // Fetch window 8192..9215 never stored, data window 0..1023
        mem_access({16'd0, 1'b1, 3'd0, r_fetch[9:0]}, !r_op[0], r_op[0], r_op[4:1],
                   {20'd0, r_addr[9:0]}, r_data);
    end
endtask

`endif

/* bench/tb_memsys.sv */
`timescale 1ns/1ps
`include "memsys_consts.svh"

module tb_memsys;

    ////////////////////////////////////////
    // Run length
    ////////////////////////////////////////

    localparam int NUM_TESTS         = 5;
    // Largest test is the random stress
    localparam int MAX_ACCESSES      = 300;
    // Worst access cost in clock cycles
    localparam int CYCLES_PER_ACCESS = 2 * `MEMSYS_RAM_LATENCY + 4;
    localparam int WATCHDOG_CYCLES   = NUM_TESTS * MAX_ACCESSES * CYCLES_PER_ACCESS;

    // Words covered by word address bits 13..0
    localparam int SHADOW_WORDS      = 16384;

    logic        clk;
    logic        rst_n;
    logic [29:0] ic_addr;
    logic        dmem_read;
    logic        dmem_write;
    logic [29:0] dmem_addr;
    logic [31:0] data_from_reg;
    logic [3:0]  dc_byte_w_en;
    logic [31:0] ic_data_out;
    logic [31:0] dmem_data_out;
    logic        mem_stall;

    // Expected memory, one word per address
    logic [31:0] shadow [SHADOW_WORDS];

    memsys_top memsys_top_i (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .ic_addr       ( ic_addr       ),
        .dmem_read     ( dmem_read     ),
        .dmem_write    ( dmem_write    ),
        .dmem_addr     ( dmem_addr     ),
        .data_from_reg ( data_from_reg ),
        .dc_byte_w_en  ( dc_byte_w_en  ),
        .ic_data_out   ( ic_data_out   ),
        .dmem_data_out ( dmem_data_out ),
        .mem_stall     ( mem_stall     )
    );

    // 4 ns clock
    always #2 clk = ~clk;

    ////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run still busy after %0d clock cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $fatal(1);
    end

    `include "tb_tasks.svh"

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        // Every DUT input known from time zero
        clk           = 1'b0;
        rst_n         = 1'b0;
        ic_addr       = '0;
        dmem_read     = 1'b0;
        dmem_write    = 1'b0;
        dmem_addr     = '0;
        data_from_reg = '0;
        dc_byte_w_en  = '0;
        for (int i = 0; i < SHADOW_WORDS; i++) begin
            shadow[i] = '0;
        end
        void'($urandom(33177));

        apply_reset();
        test_reset_state();
        test_store_load();
        test_byte_enables();
        test_dirty_eviction();
        test_random_stress();

        $display("all tests passed");
        $finish;
    end

endmodule

/* src/memsys_top.sv */
`timescale 1ns/1ps
`include "memsys_consts.svh"

module memsys_top (
    input  logic        clk,
    input  logic        rst_n,
    // Instruction fetch
    input  logic [29:0] ic_addr,
    // Data load and store
    input  logic        dmem_read,
    input  logic        dmem_write,
    input  logic [29:0] dmem_addr,
    input  logic [31:0] data_from_reg,
    input  logic [3:0]  dc_byte_w_en,
    output logic [31:0] ic_data_out,
    output logic [31:0] dmem_data_out,
    output logic        mem_stall
);

    memsys_pkg::port_req_s cache_req     [`MEMSYS_NUM_PORTS];
    memsys_pkg::port_rsp_s cache_rsp     [`MEMSYS_NUM_PORTS];
    memsys_pkg::ram_req_s  cache_ram_req [`MEMSYS_NUM_PORTS];
    memsys_pkg::ram_rsp_s  cache_ram_rsp [`MEMSYS_NUM_PORTS];
    memsys_pkg::ram_req_s  ram_req;
    memsys_pkg::ram_rsp_s  ram_rsp;

    port_router u_router (
        .ic_addr       ( ic_addr       ),
        .dmem_read     ( dmem_read     ),
        .dmem_write    ( dmem_write    ),
        .dmem_addr     ( dmem_addr     ),
        .data_from_reg ( data_from_reg ),
        .dc_byte_w_en  ( dc_byte_w_en  ),
        .cache_req     ( cache_req     ),
        .cache_rsp     ( cache_rsp     ),
        .ic_data_out   ( ic_data_out   ),
        .dmem_data_out ( dmem_data_out ),
        .mem_stall     ( mem_stall     )
    );

    // Cache 0 instructions, cache 1 data
    for (genvar i = 0; i < `MEMSYS_NUM_PORTS; i++) begin : g_cache
        block_cache u_cache (
            .clk     ( clk              ),
            .rst_n   ( rst_n            ),
            .req     ( cache_req[i]     ),
            .rsp     ( cache_rsp[i]     ),
            .ram_req ( cache_ram_req[i] ),
            .ram_rsp ( cache_ram_rsp[i] )
        );
    end

    ram_arbiter u_arb (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .cache_ram_req ( cache_ram_req ),
        .cache_ram_rsp ( cache_ram_rsp ),
        .ram_req       ( ram_req       ),
        .ram_rsp       ( ram_rsp       )
    );

    block_ram u_ram (
        .clk   ( clk     ),
        .rst_n ( rst_n   ),
        .req   ( ram_req ),
        .rsp   ( ram_rsp )
    );

endmodule

/* src/block_ram.sv */
`timescale 1ns/1ps
`include "memsys_consts.svh"

module block_ram (
    input  logic                 clk,
    input  logic                 rst_n,
    input  memsys_pkg::ram_req_s req,
    output memsys_pkg::ram_rsp_s rsp
);

    localparam int LAT = `MEMSYS_RAM_LATENCY;
    localparam int CW  = $clog2(LAT + 1);

    // Zero at start of simulation
    memsys_pkg::mem_block_u mem [`MEMSYS_RAM_BLOCKS] = '{default: '0};

    // Transaction in flight
    logic          busy_q;
    logic [CW-1:0] cnt_q;
    logic          ready;

    // Captured request
    logic                             cap_write;
    logic [`MEMSYS_BLK_ADDR_BITS-1:0] cap_addr;
    memsys_pkg::mem_block_u           cap_block;

    logic accept;

    // en ignored while busy
    assign accept = !busy_q && req.en;
    assign ready  = busy_q && (cnt_q == '0);

    ////////////////////////////////////////
    // Latency counter
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= CW'(LAT - 1);
        end else if (ready) begin
            // Idle again after the ready cycle
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cap_write <= req.write;
            cap_addr  <= req.blk_addr;
            cap_block <= req.wblock;
        end
    end

    // Write lands on the ready edge
    always_ff @(posedge clk) begin
        if (ready && cap_write) begin
            mem[cap_addr] <= cap_block;
        end
    end

    assign rsp.ready  = ready;
    assign rsp.rblock = mem[cap_addr];

endmodule

/* src/ram_arbiter.sv */
`timescale 1ns/1ps
`include "memsys_consts.svh"

module ram_arbiter (
    input  logic                 clk,
    input  logic                 rst_n,
    // Cache side
    input  memsys_pkg::ram_req_s cache_ram_req [`MEMSYS_NUM_PORTS],
    output memsys_pkg::ram_rsp_s cache_ram_rsp [`MEMSYS_NUM_PORTS],
    // Block RAM side
    output memsys_pkg::ram_req_s ram_req,
    input  memsys_pkg::ram_rsp_s ram_rsp
);

    localparam int N  = `MEMSYS_NUM_PORTS;
    localparam int OW = (N > 1) ? $clog2(N) : 1;

    // Grant state
    logic          locked_q;
    logic [OW-1:0] owner_q;
    // First requester to look at
    logic [OW-1:0] rr_q;

    logic [OW-1:0] pick;
    logic          pick_valid;
    logic [OW-1:0] sel;

    ////////////////////////////////////////
    // Round-robin pick
    ////////////////////////////////////////

    always_comb begin
        int unsigned idx;
        pick       = owner_q;
        pick_valid = 1'b0;
        for (int k = 0; k < N; k++) begin
            idx = (int'(rr_q) + k) % N;
            if (!pick_valid && cache_ram_req[idx].en) begin
                pick       = OW'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    // Held owner wins until its ready
    assign sel = locked_q ? owner_q : pick;

    always_comb begin
        ram_req    = cache_ram_req[sel];
        // Nothing forwarded when idle and unrequested
        ram_req.en = cache_ram_req[sel].en & (locked_q | pick_valid);
    end

    ////////////////////////////////////////
    // Grant register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            locked_q <= 1'b0;
            owner_q  <= '0;
            rr_q     <= '0;
        end else if (!locked_q) begin
            // RAM takes the request on this same edge
            if (pick_valid) begin
                locked_q <= 1'b1;
                owner_q  <= pick;
                rr_q     <= (int'(pick) == N - 1) ? '0 : pick + 1'b1;
            end
        end else if (ram_rsp.ready) begin
            locked_q <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Responses
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < N; i++) begin
            // Ready only to the owner, block to all
            cache_ram_rsp[i].ready  = ram_rsp.ready && locked_q && (owner_q == OW'(i));
            cache_ram_rsp[i].rblock = ram_rsp.rblock;
        end
    end

endmodule

/* src/block_cache.sv */
`timescale 1ns/1ps
`include "memsys_consts.svh"

module block_cache (
    input  logic                  clk,
    input  logic                  rst_n,
    // CPU side
    input  memsys_pkg::port_req_s req,
    output memsys_pkg::port_rsp_s rsp,
    // RAM side through the arbiter
    output memsys_pkg::ram_req_s  ram_req,
    input  memsys_pkg::ram_rsp_s  ram_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WB,
        ST_FILL
    } state_t;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    memsys_pkg::mem_block_u     lines [`MEMSYS_LINES];
    logic [`MEMSYS_TAG_BITS-1:0] tags  [`MEMSYS_LINES];
    logic [`MEMSYS_LINES-1:0]    valid;
    logic [`MEMSYS_LINES-1:0]    dirty;

    state_t state_q;

    // Address split
    logic [`MEMSYS_WORD_BITS-1:0]  word_sel;
    logic [`MEMSYS_INDEX_BITS-1:0] index;
    logic [`MEMSYS_TAG_BITS-1:0]   tag;

    assign word_sel = req.addr[`MEMSYS_WORD_BITS-1:0];
    assign index    = req.addr[`MEMSYS_WORD_BITS +: `MEMSYS_INDEX_BITS];
    assign tag      = req.addr[`MEMSYS_WORD_BITS + `MEMSYS_INDEX_BITS +: `MEMSYS_TAG_BITS];

    logic access;
    logic hit;
    logic miss;
    logic victim_dirty;
    logic wr_hit;
    logic fill_done;

    assign access       = req.rd | req.wr;
    assign hit          = valid[index] && (tags[index] == tag);
    assign miss         = access && !hit;
    assign victim_dirty = valid[index] && dirty[index];
    // Store commits only from idle
    assign wr_hit       = (state_q == ST_IDLE) && req.wr && hit;
    assign fill_done    = (state_q == ST_FILL) && ram_rsp.ready;

    ////////////////////////////////////////
    // CPU response
    ////////////////////////////////////////

    assign rsp.rdata = lines[index].words[word_sel];
    // Rises in the miss cycle, falls the cycle after the fill
    assign rsp.busy  = (state_q != ST_IDLE) || miss;

    // Store bytes merged over the current line
    memsys_pkg::mem_block_u merged;

    always_comb begin
        merged = lines[index];
        for (int b = 0; b < 4; b++) begin
            if (req.be[b]) begin
                merged.bytes[{word_sel, 2'(b)}] = req.wdata[8*b +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // RAM request
    ////////////////////////////////////////

    always_comb begin
        ram_req.en     = 1'b0;
        ram_req.write  = 1'b0;
        ram_req.wblock = lines[index];
        // Victim address for write-back, else the missing block
        ram_req.blk_addr = {tag, index};
        case (state_q)
            ST_IDLE: begin
                // Request goes out in the miss cycle itself
                ram_req.en    = miss;
                ram_req.write = victim_dirty;
            end
            ST_WB: begin
                ram_req.en    = 1'b1;
                ram_req.write = 1'b1;
            end
            ST_FILL: begin
                ram_req.en    = 1'b1;
            end
            default: ;
        endcase
        if (ram_req.write) begin
            ram_req.blk_addr = {tags[index], index};
        end
    end

    ////////////////////////////////////////
    // Miss FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (miss) begin
                        state_q <= victim_dirty ? ST_WB : ST_FILL;
                    end
                end
                ST_WB: begin
                    // Old line now in RAM
                    if (ram_rsp.ready) begin
                        state_q <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (ram_rsp.ready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Line status bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
            dirty <= '0;
        end else if (fill_done) begin
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;
        end else if (wr_hit) begin
            dirty[index] <= 1'b1;
        end
    end

    // Line data and tags
    always_ff @(posedge clk) begin
        if (fill_done) begin
            lines[index] <= ram_rsp.rblock;
            tags[index]  <= tag;
        end else if (wr_hit) begin
            lines[index] <= merged;
        end
    end

endmodule

/* src/port_router.sv */
`timescale 1ns/1ps
`include "memsys_consts.svh"

module port_router (
    // Instruction port
    input  logic [29:0]           ic_addr,
    // Data port
    input  logic                  dmem_read,
    input  logic                  dmem_write,
    input  logic [29:0]           dmem_addr,
    input  logic [31:0]           data_from_reg,
    input  logic [3:0]            dc_byte_w_en,
    // Per-cache requests and answers
    output memsys_pkg::port_req_s cache_req [`MEMSYS_NUM_PORTS],
    input  memsys_pkg::port_rsp_s cache_rsp [`MEMSYS_NUM_PORTS],
    // CPU results
    output logic [31:0]           ic_data_out,
    output logic [31:0]           dmem_data_out,
    output logic                  mem_stall
);

    // Cache slots
    localparam int IC = 0;
    localparam int DC = 1;

    logic ic_busy;
    logic dc_busy;

    assign ic_busy = cache_rsp[IC].busy;
    assign dc_busy = cache_rsp[DC].busy;

    ////////////////////////////////////////
    // Request build
    ////////////////////////////////////////

    always_comb begin
        // Fetch every cycle
        cache_req[IC].rd    = 1'b1;
        cache_req[IC].wr    = 1'b0;
        cache_req[IC].be    = 4'hF;
        cache_req[IC].addr  = ic_addr;
        cache_req[IC].wdata = '0;

        // Data port as given by the CPU
        cache_req[DC].rd    = dmem_read;
        cache_req[DC].addr  = dmem_addr;
        cache_req[DC].be    = dc_byte_w_en;
        cache_req[DC].wdata = data_from_reg;
        // Hold the store back during a fetch miss
        // It commits only in the cycle the stall drops
        cache_req[DC].wr    = dmem_write & ~ic_busy;
    end

    ////////////////////////////////////////
    // Response merge
    ////////////////////////////////////////

    // Either cache waiting on RAM holds the CPU
    assign mem_stall = ic_busy | dc_busy;

    // Combinational read data on a hit
    assign ic_data_out   = cache_rsp[IC].rdata;
    assign dmem_data_out = cache_rsp[DC].rdata;

endmodule

/* src/memsys_pkg.sv */
`include "memsys_consts.svh"

package memsys_pkg;

    ////////////////////////////////////////
    // Block payload
    ////////////////////////////////////////

    // One 256-bit block
    // Word view for loads, byte view for masked stores
    typedef union packed {
        logic [`MEMSYS_WORDS_PER_BLOCK-1:0][31:0]  words;
        logic [`MEMSYS_WORDS_PER_BLOCK*4-1:0][7:0] bytes;
    } mem_block_u;

    ////////////////////////////////////////
    // CPU side
    ////////////////////////////////////////

    // Access presented to one cache
    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [3:0]  be;
        logic [29:0] addr;
        logic [31:0] wdata;
    } port_req_s;

    // Cache answer
    typedef struct packed {
        logic [31:0] rdata;
        // Access still pending
        logic        busy;
    } port_rsp_s;

    ////////////////////////////////////////
    // RAM side
    ////////////////////////////////////////

    // Block transfer request
    typedef struct packed {
        logic                             en;
        logic                             write;
        logic [`MEMSYS_BLK_ADDR_BITS-1:0] blk_addr;
        mem_block_u                       wblock;
    } ram_req_s;

    // One-cycle ready plus read block
    typedef struct packed {
        logic       ready;
        mem_block_u rblock;
    } ram_rsp_s;

endpackage

/* src/memsys_consts.svh */
`ifndef MEMSYS_CONSTS_SVH
`define MEMSYS_CONSTS_SVH

////////////////////////////////////////
// Cache geometry
////////////////////////////////////////

// 32-bit words per block
`define MEMSYS_WORDS_PER_BLOCK 8
// Word select width inside a block
`define MEMSYS_WORD_BITS 3
// Lines per cache
`define MEMSYS_LINES 64
// Index is word address bits 8..3
`define MEMSYS_INDEX_BITS 6
// Tag is word address bits 13..9
`define MEMSYS_TAG_BITS 5

////////////////////////////////////////
// Block RAM
////////////////////////////////////////

`define MEMSYS_RAM_BLOCKS 2048
`define MEMSYS_BLK_ADDR_BITS 11
// Cycles from accepted request to ready
`define MEMSYS_RAM_LATENCY 4

// Port 0 fetches, port 1 loads and stores
`define MEMSYS_NUM_PORTS 2

`endif
